/* Bender.yml */
package:
  name: issue_stage

sources:
  - hdl/issue_pkg.sv
  - hdl/issue_ifs.sv
  - hdl/reg_scoreboard.sv
  - hdl/hazard_check.sv
  - hdl/operand_bypass.sv
  - hdl/fu_dispatch.sv
  - hdl/issue_stage.sv
  - target: test
    files:
      - verif/issue_tb.sv

/* build.f */
hdl/issue_pkg.sv
hdl/issue_ifs.sv
hdl/reg_scoreboard.sv
hdl/hazard_check.sv
hdl/operand_bypass.sv
hdl/fu_dispatch.sv
hdl/issue_stage.sv
verif/issue_tb.sv

/* hdl/fu_dispatch.sv */
module fu_dispatch import issue_pkg::*; (
    slot_if.reader      slot0,
    slot_if.reader      slot1,
    issue_rec_if.reader rec,
    input  word_t       op1,
    input  word_t       op2,
    input  word_t       op3,
    input  word_t       op4,
    output logic        alu0_en,
    output word_t       alu0_op_a,
    output word_t       alu0_op_b,
    output alu_op_t     alu0_op,
    output logic        alu1_en,
    output word_t       alu1_op_a,
    output word_t       alu1_op_b,
    output alu_op_t     alu1_op,
    output logic        agu_en,
    output logic        agu_write,
    output word_t       agu_base,
    output word_t       agu_offset,
    output word_t       agu_data,
    output msize_t      agu_msize
);

    function automatic word_t sext(input imm_t imm);
        return {{($bits(word_t) - SIGN_BIT - 1){imm[SIGN_BIT]}}, imm[SIGN_BIT:0]};
    endfunction

    always_comb begin
        alu0_en    = 1'b0;
        alu0_op_a  = '0;
        alu0_op_b  = '0;
        alu0_op    = '0;
        alu1_en    = 1'b0;
        alu1_op_a  = '0;
        alu1_op_b  = '0;
        alu1_op    = '0;
        agu_en     = 1'b0;
        agu_write  = 1'b0;
        agu_base   = '0;
        agu_offset = '0;
        agu_data   = '0;
        agu_msize  = '0;

        if (rec.fu0 == fu_alu0) begin
            alu0_en   = 1'b1;
            alu0_op_a = op1;
            alu0_op_b = slot0.use_imm ? word_t'(slot0.imm) : op2;   // zero extended
            alu0_op   = slot0.alu_op;
        end
        if (rec.fu1 == fu_alu1) begin
            alu1_en   = 1'b1;
            alu1_op_a = op3;
            alu1_op_b = slot1.use_imm ? word_t'(slot1.imm) : op4;
            alu1_op   = slot1.alu_op;
        end

        // single agu, whichever slot was sent there
        if (rec.fu0 == fu_agu) begin
            agu_en     = 1'b1;
            agu_write  = slot0.mem_write;
            agu_base   = op1;
            agu_offset = sext(slot0.imm);
            agu_data   = op2;
            agu_msize  = slot0.msize;
        end else if (rec.fu1 == fu_agu) begin
            agu_en     = 1'b1;
            agu_write  = slot1.mem_write;
            agu_base   = op3;
            agu_offset = sext(slot1.imm);
            agu_data   = op4;
            agu_msize  = slot1.msize;
        end
    end

endmodule

/* hdl/hazard_check.sv */
module hazard_check import issue_pkg::*; (
    slot_if.reader      slot0,
    slot_if.reader      slot1,
    sb_view_if.reader   sb,
    issue_rec_if.driver rec,
    input  logic        mem_halt,
    input  logic        issue_halt,
    input  logic        exception_flag,
    output reg_id_t     ra1,
    output reg_id_t     ra2,
    output reg_id_t     ra3,
    output reg_id_t     ra4
);

    logic a0_busy, b0_busy;
    logic a1_busy, b1_busy;
    logic ready0, ready1;
    logic wr0, wr1;
    logic same_dst, raw_pair, pair_ok;
    logic halt;
    logic issue0, issue1;

    // alu result can be bypassed from e2 on
    function automatic logic fwd_ok(input fu_t fu, input sb_phase_t ph);
        return (fu == fu_alu0 || fu == fu_alu1) && (ph == sb_e2 || ph == sb_e3);
    endfunction

    function automatic fu_t pick_fu(input unit_t unit, input fu_t alu);
        return (unit == unit_mem) ? fu_agu : alu;
    endfunction

    assign a0_busy = slot0.read_a && sb.pending[slot0.reg_a]
                     && !fwd_ok(sb.fu[slot0.reg_a], sb.phase[slot0.reg_a]);
    assign b0_busy = slot0.read_b && sb.pending[slot0.reg_b]
                     && !fwd_ok(sb.fu[slot0.reg_b], sb.phase[slot0.reg_b]);

    // slot1 gets no forwarding
    assign a1_busy = slot1.read_a && sb.pending[slot1.reg_a];
    assign b1_busy = slot1.read_b && sb.pending[slot1.reg_b];

    assign ready0 = slot0.valid && !a0_busy && !b0_busy;
    assign ready1 = slot1.valid && !a1_busy && !b1_busy;

    assign wr0 = slot0.write_c && (slot0.reg_c != '0);
    assign wr1 = slot1.write_c && (slot1.reg_c != '0);

    assign same_dst = wr0 && wr1 && (slot0.reg_c == slot1.reg_c);
    assign raw_pair = wr0 && ((slot1.read_a && slot1.reg_a == slot0.reg_c)
                              || (slot1.read_b && slot1.reg_b == slot0.reg_c));
    assign pair_ok  = ready1 && (slot1.unit != unit_mem) && !same_dst && !raw_pair;

    assign halt   = mem_halt || issue_halt || exception_flag;
    assign issue0 = ready0 && !halt;
    assign issue1 = issue0 && pair_ok;   // in order, slot1 never alone

    assign rec.cnt  = issue1 ? 2'd2 : (issue0 ? 2'd1 : 2'd0);
    assign rec.fu0  = issue0 ? pick_fu(slot0.unit, fu_alu0) : fu_none;
    assign rec.fu1  = issue1 ? pick_fu(slot1.unit, fu_alu1) : fu_none;
    assign rec.dst0 = (issue0 && wr0) ? slot0.reg_c : '0;
    assign rec.dst1 = (issue1 && wr1) ? slot1.reg_c : '0;

    assign ra1 = issue0 ? slot0.reg_a : '0;
    assign ra2 = issue0 ? slot0.reg_b : '0;
    assign ra3 = issue1 ? slot1.reg_a : '0;
    assign ra4 = issue1 ? slot1.reg_b : '0;

endmodule

/* hdl/issue_ifs.sv */
// one decoded instruction slot
interface slot_if import issue_pkg::*; ();
    logic    valid;
    unit_t   unit;
    reg_id_t reg_a;
    logic    read_a;
    reg_id_t reg_b;
    logic    read_b;
    reg_id_t reg_c;
    logic    write_c;
    imm_t    imm;
    logic    use_imm;
    alu_op_t alu_op;
    logic    mem_write;
    msize_t  msize;

    modport reader (
        input valid, unit, reg_a, read_a, reg_b, read_b, reg_c, write_c,
        input imm, use_imm, alu_op, mem_write, msize
    );
endinterface

// scoreboard state of every register
interface sb_view_if import issue_pkg::*; ();
    logic      pending [NUM_REGS];
    fu_t       fu      [NUM_REGS];
    sb_phase_t phase   [NUM_REGS];

    modport driver (output pending, fu, phase);
    modport reader (input pending, fu, phase);
endinterface

// what was issued this cycle
interface issue_rec_if import issue_pkg::*; ();
    logic [1:0] cnt;
    fu_t        fu0;
    fu_t        fu1;
    reg_id_t    dst0;   // 0 when nothing is written
    reg_id_t    dst1;

    modport driver (output cnt, fu0, fu1, dst0, dst1);
    modport reader (input cnt, fu0, fu1, dst0, dst1);
endinterface

/* hdl/issue_pkg.sv */
package issue_pkg;

    localparam int WORD_W = 32;
    localparam int IMM_W  = 16;

    // architectural registers, r0 is hardwired zero
    localparam int NUM_REGS = 32;

    // immediate bit copied into the upper half of the agu offset
    localparam int SIGN_BIT = 15;

    // register-file read ports shared by both slots
    localparam int NUM_READ_PORTS = 4;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [4:0]        reg_id_t;
    typedef logic [IMM_W-1:0]  imm_t;
    typedef logic [3:0]        alu_op_t;   // opaque to this stage
    typedef logic [1:0]        msize_t;

    // decoded unit class
    typedef enum logic {
        unit_alu,
        unit_mem
    } unit_t;

    // execution unit an issued instruction is sent to
    typedef enum logic [1:0] {
        fu_none,
        fu_alu0,
        fu_alu1,
        fu_agu
    } fu_t;

    // per-register result tracking through execute
    typedef enum logic [1:0] {
        sb_idle,
        sb_e1,
        sb_e2,
        sb_e3
    } sb_phase_t;

endpackage

/* hdl/issue_stage.sv */
module issue_stage import issue_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       slot0_valid,
    input  unit_t      slot0_unit,
    input  reg_id_t    slot0_reg_a,
    input  logic       slot0_read_a,
    input  reg_id_t    slot0_reg_b,
    input  logic       slot0_read_b,
    input  reg_id_t    slot0_reg_c,
    input  logic       slot0_write_c,
    input  imm_t       slot0_imm,
    input  logic       slot0_use_imm,
    input  alu_op_t    slot0_alu_op,
    input  logic       slot0_mem_write,
    input  msize_t     slot0_msize,
    input  logic       slot1_valid,
    input  unit_t      slot1_unit,
    input  reg_id_t    slot1_reg_a,
    input  logic       slot1_read_a,
    input  reg_id_t    slot1_reg_b,
    input  logic       slot1_read_b,
    input  reg_id_t    slot1_reg_c,
    input  logic       slot1_write_c,
    input  imm_t       slot1_imm,
    input  logic       slot1_use_imm,
    input  alu_op_t    slot1_alu_op,
    input  logic       slot1_mem_write,
    input  msize_t     slot1_msize,
    input  word_t      rd1,
    input  word_t      rd2,
    input  word_t      rd3,
    input  word_t      rd4,
    input  word_t      alu0_p2,
    input  word_t      alu0_p3,
    input  word_t      alu1_p2,
    input  word_t      alu1_p3,
    input  logic       stall_e1,
    input  logic       stall_e2,
    input  logic       stall_e3,
    input  logic       mem_halt,
    input  logic       issue_halt,
    input  logic       exception_flag,
    output logic [1:0] issue_cnt,
    output reg_id_t    ra1,
    output reg_id_t    ra2,
    output reg_id_t    ra3,
    output reg_id_t    ra4,
    output logic       alu0_en,
    output word_t      alu0_op_a,
    output word_t      alu0_op_b,
    output alu_op_t    alu0_op,
    output logic       alu1_en,
    output word_t      alu1_op_a,
    output word_t      alu1_op_b,
    output alu_op_t    alu1_op,
    output logic       agu_en,
    output logic       agu_write,
    output word_t      agu_base,
    output word_t      agu_offset,
    output word_t      agu_data,
    output msize_t     agu_msize
);

    slot_if      slot0_if ();
    slot_if      slot1_if ();
    sb_view_if   sb_if ();
    issue_rec_if rec_if ();

    word_t op1, op2, op3, op4;   // resolved operands

    assign slot0_if.valid     = slot0_valid;
    assign slot0_if.unit      = slot0_unit;
    assign slot0_if.reg_a     = slot0_reg_a;
    assign slot0_if.read_a    = slot0_read_a;
    assign slot0_if.reg_b     = slot0_reg_b;
    assign slot0_if.read_b    = slot0_read_b;
    assign slot0_if.reg_c     = slot0_reg_c;
    assign slot0_if.write_c   = slot0_write_c;
    assign slot0_if.imm       = slot0_imm;
    assign slot0_if.use_imm   = slot0_use_imm;
    assign slot0_if.alu_op    = slot0_alu_op;
    assign slot0_if.mem_write = slot0_mem_write;
    assign slot0_if.msize     = slot0_msize;

    assign slot1_if.valid     = slot1_valid;
    assign slot1_if.unit      = slot1_unit;
    assign slot1_if.reg_a     = slot1_reg_a;
    assign slot1_if.read_a    = slot1_read_a;
    assign slot1_if.reg_b     = slot1_reg_b;
    assign slot1_if.read_b    = slot1_read_b;
    assign slot1_if.reg_c     = slot1_reg_c;
    assign slot1_if.write_c   = slot1_write_c;
    assign slot1_if.imm       = slot1_imm;
    assign slot1_if.use_imm   = slot1_use_imm;
    assign slot1_if.alu_op    = slot1_alu_op;
    assign slot1_if.mem_write = slot1_mem_write;
    assign slot1_if.msize     = slot1_msize;

    assign issue_cnt = rec_if.cnt;

    reg_scoreboard u_scoreboard (
        .clk      (clk),
        .resetn   (resetn),
        .rec      (rec_if),
        .sb       (sb_if),
        .stall_e1 (stall_e1),
        .stall_e2 (stall_e2),
        .stall_e3 (stall_e3)
    );

    hazard_check u_hazard (
        .slot0          (slot0_if),
        .slot1          (slot1_if),
        .sb             (sb_if),
        .rec            (rec_if),
        .mem_halt       (mem_halt),
        .issue_halt     (issue_halt),
        .exception_flag (exception_flag),
        .ra1            (ra1),
        .ra2            (ra2),
        .ra3            (ra3),
        .ra4            (ra4)
    );

    operand_bypass u_bypass (
        .sb      (sb_if),
        .ra1     (ra1),
        .ra2     (ra2),
        .ra3     (ra3),
        .ra4     (ra4),
        .rd1     (rd1),
        .rd2     (rd2),
        .rd3     (rd3),
        .rd4     (rd4),
        .alu0_p2 (alu0_p2),
        .alu0_p3 (alu0_p3),
        .alu1_p2 (alu1_p2),
        .alu1_p3 (alu1_p3),
        .op1     (op1),
        .op2     (op2),
        .op3     (op3),
        .op4     (op4)
    );

    fu_dispatch u_dispatch (
        .slot0      (slot0_if),
        .slot1      (slot1_if),
        .rec        (rec_if),
        .op1        (op1),
        .op2        (op2),
        .op3        (op3),
        .op4        (op4),
        .alu0_en    (alu0_en),
        .alu0_op_a  (alu0_op_a),
        .alu0_op_b  (alu0_op_b),
        .alu0_op    (alu0_op),
        .alu1_en    (alu1_en),
        .alu1_op_a  (alu1_op_a),
        .alu1_op_b  (alu1_op_b),
        .alu1_op    (alu1_op),
        .agu_en     (agu_en),
        .agu_write  (agu_write),
        .agu_base   (agu_base),
        .agu_offset (agu_offset),
        .agu_data   (agu_data),
        .agu_msize  (agu_msize)
    );

endmodule

/* hdl/operand_bypass.sv */
module operand_bypass import issue_pkg::*; (
    sb_view_if.reader sb,
    input  reg_id_t   ra1,
    input  reg_id_t   ra2,
    input  reg_id_t   ra3,
    input  reg_id_t   ra4,
    input  word_t     rd1,
    input  word_t     rd2,
    input  word_t     rd3,
    input  word_t     rd4,
    input  word_t     alu0_p2,
    input  word_t     alu0_p3,
    input  word_t     alu1_p2,
    input  word_t     alu1_p3,
    output word_t     op1,
    output word_t     op2,
    output word_t     op3,
    output word_t     op4
);

    reg_id_t ra [NUM_READ_PORTS];
    word_t   rd [NUM_READ_PORTS];
    word_t   op [NUM_READ_PORTS];

    assign ra = '{ra1, ra2, ra3, ra4};
    assign rd = '{rd1, rd2, rd3, rd4};

    always_comb begin
        for (int k = 0; k < NUM_READ_PORTS; k++) begin
            op[k] = rd[k];
            if (sb.pending[ra[k]]) begin
                case (sb.fu[ra[k]])
                    fu_alu0: begin
                        if (sb.phase[ra[k]] == sb_e2) op[k] = alu0_p2;
                        else if (sb.phase[ra[k]] == sb_e3) op[k] = alu0_p3;
                    end
                    fu_alu1: begin
                        if (sb.phase[ra[k]] == sb_e2) op[k] = alu1_p2;
                        else if (sb.phase[ra[k]] == sb_e3) op[k] = alu1_p3;
                    end
                    default: ;   // agu result not forwarded
                endcase
            end
        end
    end

    assign op1 = op[0];
    assign op2 = op[1];
    assign op3 = op[2];
    assign op4 = op[3];

endmodule

/* hdl/reg_scoreboard.sv */
module reg_scoreboard import issue_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    issue_rec_if.reader rec,
    sb_view_if.driver   sb,
    input  logic        stall_e1,
    input  logic        stall_e2,
    input  logic        stall_e3
);

    // r0 is never tracked
    sb_phase_t phase_q [1:NUM_REGS-1];
    sb_phase_t phase_d [1:NUM_REGS-1];
    fu_t       owner_q [1:NUM_REGS-1];
    fu_t       owner_d [1:NUM_REGS-1];

    always_comb begin
        for (int i = 1; i < NUM_REGS; i++) begin
            phase_d[i] = phase_q[i];
            owner_d[i] = owner_q[i];

            case (phase_q[i])
                sb_e1: if (!stall_e1) phase_d[i] = sb_e2;
                sb_e2: if (!stall_e2) phase_d[i] = sb_e3;
                sb_e3: if (!stall_e3) phase_d[i] = sb_idle;
                default: ;
            endcase

            // a fresh issue restarts the register
            if (rec.dst0 == reg_id_t'(i)) begin
                phase_d[i] = sb_e1;
                owner_d[i] = rec.fu0;
            end
            if (rec.dst1 == reg_id_t'(i)) begin
                phase_d[i] = sb_e1;
                owner_d[i] = rec.fu1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                phase_q[i] <= sb_idle;
            end
        end else begin
            phase_q <= phase_d;
            owner_q <= owner_d;
        end
    end

    always_comb begin
        sb.pending[0] = 1'b0;
        sb.fu[0]      = fu_none;
        sb.phase[0]   = sb_idle;
        for (int i = 1; i < NUM_REGS; i++) begin
            sb.pending[i] = (phase_q[i] != sb_idle);
            sb.fu[i]      = sb.pending[i] ? owner_q[i] : fu_none;
            sb.phase[i]   = phase_q[i];
        end
    end

endmodule

/* verif/issue_tb.sv */
module issue_tb import issue_pkg::*; ();

    typedef struct packed {
        logic [127:0] tag;
        logic [7:0]   flags0;   // valid unit read_a read_b write_c use_imm mem_write
        logic [4:0]   a0;
        logic [4:0]   b0;
        logic [4:0]   c0;
        logic [15:0]  imm0;
        logic [3:0]   aluop0;
        logic [1:0]   sz0;
        logic [7:0]   flags1;
        logic [4:0]   a1;
        logic [4:0]   b1;
        logic [4:0]   c1;
        logic [15:0]  imm1;
        logic [3:0]   aluop1;
        logic [1:0]   sz1;
        logic [5:0]   ctrl;     // stall_e1 stall_e2 stall_e3 mem_halt issue_halt exception
        logic [1:0]   cnt;
        logic [15:0]  src;      // one nibble per operand, op1 first
    } test_vec_t;

    logic       clk;
    logic       resetn;
    logic       slot0_valid, slot0_read_a, slot0_read_b, slot0_write_c;
    logic       slot0_use_imm, slot0_mem_write;
    logic       slot1_valid, slot1_read_a, slot1_read_b, slot1_write_c;
    logic       slot1_use_imm, slot1_mem_write;
    unit_t      slot0_unit, slot1_unit;
    reg_id_t    slot0_reg_a, slot0_reg_b, slot0_reg_c;
    reg_id_t    slot1_reg_a, slot1_reg_b, slot1_reg_c;
    imm_t       slot0_imm, slot1_imm;
    alu_op_t    slot0_alu_op, slot1_alu_op;
    msize_t     slot0_msize, slot1_msize;
    word_t      rd1, rd2, rd3, rd4;
    word_t      alu0_p2, alu0_p3, alu1_p2, alu1_p3;
    logic       stall_e1, stall_e2, stall_e3, mem_halt, issue_halt, exception_flag;
    logic [1:0] issue_cnt;
    reg_id_t    ra1, ra2, ra3, ra4;
    logic       alu0_en, alu1_en, agu_en, agu_write;
    word_t      alu0_op_a, alu0_op_b, alu1_op_a, alu1_op_b;
    alu_op_t    alu0_op, alu1_op;
    word_t      agu_base, agu_offset, agu_data;
    msize_t     agu_msize;

    test_vec_t tests [$];
    integer    seed = 32'h99b97056;
    int        errors = 0;
    int        test_errors = 0;
    int        failed = 0;
    int        cycles = 0;
    int        cycle_limit = 0;

    issue_stage DUT (.*);

    // register file contents follow the address
    function automatic word_t rf_word(input reg_id_t addr);
        return {3'b101, addr, 8'h3c, ~addr, 3'b010, addr, 3'b000};
    endfunction

    assign rd1 = rf_word(ra1);
    assign rd2 = rf_word(ra2);
    assign rd3 = rf_word(ra3);
    assign rd4 = rf_word(ra4);

    function automatic word_t src_word(input logic [3:0] code, input reg_id_t addr);
        case (code)
            4'd1:    return alu0_p2;
            4'd2:    return alu0_p3;
            4'd3:    return alu1_p2;
            4'd4:    return alu1_p3;
            default: return rf_word(addr);
        endcase
    endfunction

    function automatic word_t sign_ext(input imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic load_tests();
        int             fd;
        int             n;
        logic [8*256-1:0] line;
        logic [8*16-1:0]  tag;
        logic [31:0]    f [17];
        test_vec_t      tv;
        fd = $fopen("verif/issue_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/issue_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            tag, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                if (n == 18) begin   // comments and blank lines fall through
                    tv = {tag, f[0][7:0], f[1][4:0], f[2][4:0], f[3][4:0], f[4][15:0],
                          f[5][3:0], f[6][1:0], f[7][7:0], f[8][4:0], f[9][4:0],
                          f[10][4:0], f[11][15:0], f[12][3:0], f[13][1:0], f[14][5:0],
                          f[15][1:0], f[16][15:0]};
                    tests.push_back(tv);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_vec(input test_vec_t tv);
        slot0_valid     = tv.flags0[6];
        slot0_unit      = unit_t'(tv.flags0[5]);
        slot0_read_a    = tv.flags0[4];
        slot0_read_b    = tv.flags0[3];
        slot0_write_c   = tv.flags0[2];
        slot0_use_imm   = tv.flags0[1];
        slot0_mem_write = tv.flags0[0];
        slot0_reg_a     = tv.a0;
        slot0_reg_b     = tv.b0;
        slot0_reg_c     = tv.c0;
        slot0_imm       = tv.imm0;
        slot0_alu_op    = tv.aluop0;
        slot0_msize     = tv.sz0;
        slot1_valid     = tv.flags1[6];
        slot1_unit      = unit_t'(tv.flags1[5]);
        slot1_read_a    = tv.flags1[4];
        slot1_read_b    = tv.flags1[3];
        slot1_write_c   = tv.flags1[2];
        slot1_use_imm   = tv.flags1[1];
        slot1_mem_write = tv.flags1[0];
        slot1_reg_a     = tv.a1;
        slot1_reg_b     = tv.b1;
        slot1_reg_c     = tv.c1;
        slot1_imm       = tv.imm1;
        slot1_alu_op    = tv.aluop1;
        slot1_msize     = tv.sz1;
        {stall_e1, stall_e2, stall_e3, mem_halt, issue_halt, exception_flag} = tv.ctrl;
        alu0_p2 = $random(seed);   // fresh bypass words every cycle
        alu0_p3 = $random(seed);
        alu1_p2 = $random(seed);
        alu1_p3 = $random(seed);
    endtask

    task automatic check_vec(input test_vec_t tv);
        logic    iss0, iss1, mem0, mem1;
        reg_id_t e_ra1, e_ra2, e_ra3, e_ra4;
        word_t   v1, v2, v3, v4;
        iss0  = (tv.cnt != 2'd0);
        iss1  = (tv.cnt == 2'd2);
        mem0  = tv.flags0[5];
        mem1  = tv.flags1[5];
        e_ra1 = iss0 ? tv.a0 : '0;
        e_ra2 = iss0 ? tv.b0 : '0;
        e_ra3 = iss1 ? tv.a1 : '0;
        e_ra4 = iss1 ? tv.b1 : '0;
        v1 = src_word(tv.src[15:12], e_ra1);
        v2 = src_word(tv.src[11:8], e_ra2);
        v3 = src_word(tv.src[7:4], e_ra3);
        v4 = src_word(tv.src[3:0], e_ra4);
        check_val("issue_cnt", issue_cnt, tv.cnt);
        check_val("ra1", ra1, e_ra1);
        check_val("ra2", ra2, e_ra2);
        check_val("ra3", ra3, e_ra3);
        check_val("ra4", ra4, e_ra4);
        check_val("alu0_en", alu0_en, iss0 && !mem0);
        check_val("alu1_en", alu1_en, iss1 && !mem1);
        check_val("agu_en", agu_en, iss0 && mem0);   // memory op never pairs in slot1
        if (iss0 && !mem0) begin
            check_val("alu0_op_a", alu0_op_a, v1);
            check_val("alu0_op_b", alu0_op_b, tv.flags0[1] ? {16'h0, tv.imm0} : v2);
            check_val("alu0_op", alu0_op, tv.aluop0);
        end
        if (iss1 && !mem1) begin
            check_val("alu1_op_a", alu1_op_a, v3);
            check_val("alu1_op_b", alu1_op_b, tv.flags1[1] ? {16'h0, tv.imm1} : v4);
            check_val("alu1_op", alu1_op, tv.aluop1);
        end
        if (iss0 && mem0) begin
            check_val("agu_base", agu_base, v1);
            check_val("agu_offset", agu_offset, sign_ext(tv.imm0));
            check_val("agu_data", agu_data, v2);
            check_val("agu_write", agu_write, tv.flags0[0]);
            check_val("agu_msize", agu_msize, tv.sz0);
        end
    endtask

    initial begin
        apply_vec('0);
        resetn = 1'b0;
        load_tests();
        if (tests.size() == 0) begin
            $display("no test vectors were loaded");
            errors++;
        end
        cycle_limit = tests.size() + 20;
        repeat (8) @(posedge clk);
        #1 resetn = 1'b1;
        foreach (tests[i]) begin
            @(posedge clk);
            #1 apply_vec(tests[i]);
            @(negedge clk);   // outputs settled mid cycle
            test_errors = 0;
            check_vec(tests[i]);
            errors += test_errors;
            if (test_errors != 0)
                failed++;
            $display("test %0d %0s: %s", i, tests[i].tag, (test_errors == 0) ? "ok" : "failed");
        end
        $display("%0d tests, %0d failed, %0d check errors", tests.size(), failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* verif/issue_tests.txt */
# tag f0 a0 b0 c0 imm0 op0 sz0 f1 a1 b1 c1 imm1 op1 sz1 ctrl cnt src  (all hex)
# f = valid unit read_a read_b write_c use_imm mem_write, src nibble 0 rf 1 a0p2 2 a0p3 3 a1p2 4 a1p3
dual_alu    5c 01 02 03 0000 1 0  56 04 00 05 8001 2 0  00 2 0000
dual_imm    56 06 00 07 1234 3 0  5c 08 09 0a 0000 4 0  00 2 0000
same_dst    5c 0b 0c 0d 0000 5 0  5c 0e 0f 0d 0000 6 0  00 1 0000
raw_pair    5c 10 11 12 0000 7 0  5c 12 13 14 0000 8 0  00 1 0000
mem_slot1   5c 01 02 15 0000 9 0  74 16 00 17 0010 0 2  00 1 0000
slot1_off   56 18 00 19 00ff a 0  00 00 00 00 0000 0 0  00 1 0000
producer    5c 01 02 1a 0000 1 0  00 00 00 00 0000 0 0  00 1 0000
blocked_e1  5c 1a 02 1b 0000 2 0  00 00 00 00 0000 0 0  00 0 0000
fwd_a0p2    5c 1a 02 1b 0000 2 0  00 00 00 00 0000 0 0  00 1 1000
fwd_a0p3    5c 03 1a 1c 0000 3 0  56 01 00 1d 0005 4 0  00 2 0200
a1_blocked  56 1d 00 1e 0001 5 0  00 00 00 00 0000 0 0  00 0 0000
fwd_a1p2    5c 1d 1c 1e 0000 6 0  00 00 00 00 0000 0 0  00 1 3100
fwd_a1p3    5c 1b 1d 1f 0000 7 0  5c 1c 02 01 0000 8 0  00 1 0400
load        74 02 00 09 fff0 0 2  00 00 00 00 0000 0 0  00 1 0000
ld_use_e1   5c 09 01 0b 0000 1 0  00 00 00 00 0000 0 0  00 0 0000
ld_use_st1  5c 09 01 0b 0000 1 0  00 00 00 00 0000 0 0  10 0 0000
ld_use_st2  5c 09 01 0b 0000 1 0  00 00 00 00 0000 0 0  10 0 0000
ld_use_e2   5c 09 01 0b 0000 1 0  00 00 00 00 0000 0 0  00 0 0000
ld_use_e3   5c 09 01 0b 0000 1 0  00 00 00 00 0000 0 0  00 0 0000
ld_use_ok   5c 09 01 0b 0000 1 0  00 00 00 00 0000 0 0  00 1 0000
mem_halt    5c 01 02 0c 0000 1 0  5c 04 05 0e 0000 2 0  04 0 0000
issue_halt  5c 01 02 0c 0000 1 0  5c 04 05 0e 0000 2 0  02 0 0000
exception   5c 01 02 0c 0000 1 0  5c 04 05 0e 0000 2 0  01 0 0000
no_halt     5c 01 02 0c 0000 1 0  5c 04 05 0e 0000 2 0  00 2 0000
store       79 03 04 00 8004 0 1  56 06 00 07 0042 3 0  00 2 0000
store_halt  79 03 04 00 8004 0 1  00 00 00 00 0000 0 0  04 0 0000
idle        00 00 00 00 0000 0 0  00 00 00 00 0000 0 0  00 0 0000
